// ==== design/clk_pwr_pkg.sv ====
package clk_pwr_pkg;

    // Lower encoding means more performance
    typedef enum logic [2:0] {
        PWR_MAXIMUM    = 3'd0,
        PWR_HIGH       = 3'd1,
        PWR_MEDIUM     = 3'd2,
        PWR_LOW        = 3'd3,
        PWR_MINIMAL    = 3'd4,
        PWR_SLEEP      = 3'd5,
        PWR_DEEP_SLEEP = 3'd6,
        PWR_SHUTDOWN   = 3'd7
    } power_mode_e;

    localparam int NUM_DOMAINS = 12;

    // Domain classes as index masks
    localparam logic [NUM_DOMAINS-1:0] DOM_SYMBOL   = 12'h00f;
    localparam logic [NUM_DOMAINS-1:0] DOM_QUARTER  = 12'h070;
    localparam logic [NUM_DOMAINS-1:0] DOM_PROTOCOL = 12'h180;
    localparam logic [NUM_DOMAINS-1:0] DOM_SIDEBAND = 12'h200;
    localparam logic [NUM_DOMAINS-1:0] DOM_MGMT     = 12'h400;
    localparam logic [NUM_DOMAINS-1:0] DOM_DEBUG    = 12'h800;

    // Enabled power per domain, index 0 first
    localparam logic [15:0] DOM_POWER_MW [NUM_DOMAINS] = '{
        16'd800, 16'd800, 16'd800, 16'd800,
        16'd200, 16'd200, 16'd200,
        16'd100, 16'd100,
        16'd50, 16'd25, 16'd10
    };
    localparam logic [15:0] LEAKAGE_MW   = 16'd5;
    localparam logic [31:0] MAX_POWER_MW = 32'd10000;

    // Rail level by [rail][mode]; rails are 0p6, 0p8, 1p0, aux
    localparam logic [2:0] VDD_LEVELS [4][8] = '{
        '{3'd7, 3'd6, 3'd5, 3'd4, 3'd0, 3'd0, 3'd0, 3'd0},
        '{3'd7, 3'd6, 3'd5, 3'd4, 3'd0, 3'd0, 3'd0, 3'd0},
        '{3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd0, 3'd0, 3'd0},
        '{3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd5, 3'd0}
    };
    localparam logic [15:0] VDD_BASE_MV = 16'd600;
    localparam logic [15:0] VDD_STEP_MV = 16'd50;

    localparam logic [7:0] ACT_HOLD_TH = 8'hc0;
    localparam logic [7:0] ACT_OFF_TH  = 8'h40;

    localparam int PRED_W = 18;
    localparam logic [PRED_W-1:0] PRED_TRAFFIC_W = 18'd4;
    localparam logic [PRED_W-1:0] PRED_THERMAL_W = 18'd2;
    localparam logic [PRED_W-1:0] TH_LOW_MW      = 18'd5000;
    localparam logic [PRED_W-1:0] TH_MEDIUM_MW   = 18'd3000;
    localparam logic [PRED_W-1:0] TH_HIGH_MW     = 18'd1000;

    localparam logic [7:0] ADDR_CTRL    = 8'h00;
    localparam logic [7:0] ADDR_STATUS  = 8'h04;
    localparam logic [7:0] ADDR_DOMAINS = 8'h08;
    localparam logic [7:0] ADDR_POWER   = 8'h0c;
    localparam logic [7:0] ADDR_PREDICT = 8'h10;

    // Deepest mode in which a domain may still run
    function automatic power_mode_e dom_ceiling(input int unsigned d);
        if (DOM_SYMBOL[d]) return PWR_MEDIUM;
        if (DOM_QUARTER[d] || DOM_PROTOCOL[d]) return PWR_LOW;
        if (DOM_SIDEBAND[d]) return PWR_DEEP_SLEEP;  // Off only at shutdown
        if (DOM_MGMT[d]) return PWR_MINIMAL;
        if (DOM_DEBUG[d]) return PWR_HIGH;
        return PWR_MAXIMUM;
    endfunction

endpackage

// ==== design/apb_cfg_regs.sv ====
`timescale 1ns/1ps

module apb_cfg_regs (
    input  logic                         clk_ref,
    input  logic                         rst_n,
    input  logic [7:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic                         pll_locked,
    input  clk_pwr_pkg::power_mode_e     power_mode,
    input  clk_pwr_pkg::power_mode_e     recommended_mode,
    input  logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_enable,
    input  logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_stable,
    input  logic [31:0]                  total_power_mw,
    input  logic [clk_pwr_pkg::PRED_W-1:0] prediction_mw,
    output logic                         pll_enable,
    output logic                         ml_enable,
    output clk_pwr_pkg::power_mode_e     global_mode
);

    logic        access;
    logic        addr_hit;
    logic [31:0] rd_data;

    assign access = psel && penable;
    assign pready = 1'b1;  // Zero wait states

    // Control register, written at the access edge
    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n) begin
            pll_enable  <= 1'b0;
            ml_enable   <= 1'b0;
            global_mode <= clk_pwr_pkg::PWR_MAXIMUM;
        end else if (access && pwrite && paddr == clk_pwr_pkg::ADDR_CTRL) begin
            pll_enable  <= pwdata[0];
            ml_enable   <= pwdata[1];
            global_mode <= clk_pwr_pkg::power_mode_e'(pwdata[4:2]);
        end
    end

    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (paddr)
            clk_pwr_pkg::ADDR_CTRL:    rd_data = {27'd0, global_mode, ml_enable, pll_enable};
            clk_pwr_pkg::ADDR_STATUS:  rd_data = {24'd0, 1'b0, recommended_mode,
                                                  pll_locked, power_mode};
            clk_pwr_pkg::ADDR_DOMAINS: rd_data = {4'd0, domain_stable, 4'd0, domain_enable};
            clk_pwr_pkg::ADDR_POWER:   rd_data = total_power_mw;
            clk_pwr_pkg::ADDR_PREDICT: rd_data = {14'd0, prediction_mw};
            default:                   addr_hit = 1'b0;
        endcase
    end

    // Unmapped reads return zero with the error flag
    assign prdata  = (access && !pwrite) ? rd_data : '0;
    assign pslverr = access && !addr_hit;

endmodule

// ==== design/power_predictor.sv ====
`timescale 1ns/1ps

module power_predictor (
    input  logic                           clk_ref,
    input  logic                           rst_n,
    input  logic                           ml_enable,
    input  logic [15:0]                    traffic_prediction,
    input  logic [7:0]                     thermal_state,
    output logic [clk_pwr_pkg::PRED_W-1:0] prediction_mw,
    output clk_pwr_pkg::power_mode_e       recommended_mode
);

    logic [clk_pwr_pkg::PRED_W-1:0] weighted;

    assign weighted = 18'(traffic_prediction) * clk_pwr_pkg::PRED_TRAFFIC_W
                    + 18'(thermal_state) * clk_pwr_pkg::PRED_THERMAL_W;

    // Stage 1 registers the sum, stage 2 maps it to a mode
    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n) begin
            prediction_mw    <= '0;
            recommended_mode <= clk_pwr_pkg::PWR_MEDIUM;
        end else if (ml_enable) begin
            prediction_mw <= weighted;
            if (prediction_mw > clk_pwr_pkg::TH_LOW_MW)
                recommended_mode <= clk_pwr_pkg::PWR_LOW;
            else if (prediction_mw > clk_pwr_pkg::TH_MEDIUM_MW)
                recommended_mode <= clk_pwr_pkg::PWR_MEDIUM;
            else if (prediction_mw > clk_pwr_pkg::TH_HIGH_MW)
                recommended_mode <= clk_pwr_pkg::PWR_HIGH;
            else
                recommended_mode <= clk_pwr_pkg::PWR_MAXIMUM;  // Light load
        end
    end

endmodule

// ==== design/pll_mode_ctrl.sv ====
`timescale 1ns/1ps

module pll_mode_ctrl (
    input  logic                     clk_ref,
    input  logic                     rst_n,
    input  logic                     pll_enable,
    input  logic                     ml_enable,
    input  clk_pwr_pkg::power_mode_e global_mode,
    input  clk_pwr_pkg::power_mode_e recommended_mode,
    output logic                     pll_locked,
    output clk_pwr_pkg::power_mode_e power_mode
);

    // Lock follows enable one cycle later
    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n) begin
            pll_locked <= 1'b0;
            power_mode <= clk_pwr_pkg::PWR_MEDIUM;
        end else begin
            pll_locked <= pll_enable;
            power_mode <= ml_enable ? recommended_mode : global_mode;
        end
    end

endmodule

// ==== design/domain_gate_ctrl.sv ====
`timescale 1ns/1ps

module domain_gate_ctrl #(
    parameter int num_lanes = 16
) (
    input  logic                         clk_ref,
    input  logic                         rst_n,
    input  logic                         pll_locked,
    input  clk_pwr_pkg::power_mode_e     power_mode,
    input  logic                         ml_enable,
    input  logic [num_lanes-1:0]         lane_active,
    input  logic [7:0]                   activity_prediction [clk_pwr_pkg::NUM_DOMAINS-1:0],
    output logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_enable,
    output logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_stable,
    output logic [num_lanes-1:0]         lane_clock_enabled
);

    localparam logic [7:0] STABLE_TH = 8'd16;

    logic       any_lane;
    logic       lane_mode_ok;
    logic [7:0] stab_cnt [clk_pwr_pkg::NUM_DOMAINS-1:0];

    assign any_lane     = |lane_active;
    assign lane_mode_ok = power_mode <= clk_pwr_pkg::PWR_LOW;

    for (genvar d = 0; d < clk_pwr_pkg::NUM_DOMAINS; d++) begin : g_dom
        logic base_en;

        // Ceiling check, symbol domains also need a live lane
        assign base_en = pll_locked
                      && (power_mode <= clk_pwr_pkg::dom_ceiling(d))
                      && (!clk_pwr_pkg::DOM_SYMBOL[d] || any_lane);

        always_ff @(posedge clk_ref or negedge rst_n) begin
            if (!rst_n) begin
                domain_enable[d] <= 1'b0;
            end else if (ml_enable && activity_prediction[d] > clk_pwr_pkg::ACT_HOLD_TH) begin
                domain_enable[d] <= domain_enable[d];  // Busy domain holds its state
            end else if (ml_enable && activity_prediction[d] < clk_pwr_pkg::ACT_OFF_TH) begin
                domain_enable[d] <= 1'b0;
            end else begin
                domain_enable[d] <= base_en;
            end
        end

        // Saturating up-counter, cleared while gated
        always_ff @(posedge clk_ref or negedge rst_n) begin
            if (!rst_n)
                stab_cnt[d] <= '0;
            else if (!domain_enable[d])
                stab_cnt[d] <= '0;
            else if (stab_cnt[d] != 8'hff)
                stab_cnt[d] <= stab_cnt[d] + 8'd1;
        end

        assign domain_stable[d] = stab_cnt[d] > STABLE_TH;
    end

    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n)
            lane_clock_enabled <= '0;
        else
            lane_clock_enabled <= lane_active & {num_lanes{domain_enable[0] && lane_mode_ok}};
    end

endmodule

// ==== design/vdd_ctrl.sv ====
`timescale 1ns/1ps

module vdd_ctrl (
    input  logic                     clk_ref,
    input  logic                     rst_n,
    input  clk_pwr_pkg::power_mode_e power_mode,
    output logic [2:0]               vdd_0p6_level,
    output logic [2:0]               vdd_0p8_level,
    output logic [2:0]               vdd_1p0_level,
    output logic [2:0]               vdd_aux_level,
    output logic [15:0]              current_voltage_mv
);

    logic [2:0] lvl_0p6_next;

    assign lvl_0p6_next = clk_pwr_pkg::VDD_LEVELS[0][power_mode];

    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n) begin
            vdd_0p6_level      <= '0;
            vdd_0p8_level      <= '0;
            vdd_1p0_level      <= '0;
            vdd_aux_level      <= '0;
            current_voltage_mv <= clk_pwr_pkg::VDD_BASE_MV;  // Level zero
        end else begin
            vdd_0p6_level <= lvl_0p6_next;
            vdd_0p8_level <= clk_pwr_pkg::VDD_LEVELS[1][power_mode];
            vdd_1p0_level <= clk_pwr_pkg::VDD_LEVELS[2][power_mode];
            vdd_aux_level <= clk_pwr_pkg::VDD_LEVELS[3][power_mode];
            // Same edge as the levels, so use the next 0p6 level
            current_voltage_mv <= clk_pwr_pkg::VDD_BASE_MV
                                + clk_pwr_pkg::VDD_STEP_MV * 16'(lvl_0p6_next);
        end
    end

endmodule

// ==== design/power_estimator.sv ====
`timescale 1ns/1ps

module power_estimator (
    input  logic                                clk_ref,
    input  logic                                rst_n,
    input  logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_enable,
    output logic [31:0]                         total_power_mw,
    output logic [31:0]                         power_saved_mw
);

    logic [31:0] power_sum;

    // Class power when running, leakage when gated
    always_comb begin
        power_sum = '0;
        for (int d = 0; d < clk_pwr_pkg::NUM_DOMAINS; d++) begin
            if (domain_enable[d])
                power_sum = power_sum + 32'(clk_pwr_pkg::DOM_POWER_MW[d]);
            else
                power_sum = power_sum + 32'(clk_pwr_pkg::LEAKAGE_MW);
        end
    end

    always_ff @(posedge clk_ref or negedge rst_n) begin
        if (!rst_n) begin
            total_power_mw <= '0;
            power_saved_mw <= '0;
        end else begin
            total_power_mw <= power_sum;
            power_saved_mw <= clk_pwr_pkg::MAX_POWER_MW - power_sum;
        end
    end

endmodule

// ==== design/clk_pwr_top.sv ====
`timescale 1ns/1ps

module clk_pwr_top #(
    parameter int num_lanes = 16
) (
    input  logic                         clk_ref,
    input  logic                         rst_n,
    input  logic [7:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic [num_lanes-1:0]         lane_active,
    input  logic [7:0]                   activity_prediction [clk_pwr_pkg::NUM_DOMAINS-1:0],
    input  logic [15:0]                  traffic_prediction,
    input  logic [7:0]                   thermal_state,
    output logic                         pll_locked,
    output clk_pwr_pkg::power_mode_e     power_mode,
    output clk_pwr_pkg::power_mode_e     recommended_mode,
    output logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_enable,
    output logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_stable,
    output logic [num_lanes-1:0]         lane_clock_enabled,
    output logic [2:0]                   vdd_0p6_level,
    output logic [2:0]                   vdd_0p8_level,
    output logic [2:0]                   vdd_1p0_level,
    output logic [2:0]                   vdd_aux_level,
    output logic [15:0]                  current_voltage_mv,
    output logic [31:0]                  total_power_mw,
    output logic [31:0]                  power_saved_mw
);

    logic                           pll_enable;
    logic                           ml_enable;
    clk_pwr_pkg::power_mode_e       global_mode;
    logic [clk_pwr_pkg::PRED_W-1:0] prediction_mw;

    apb_cfg_regs u_apb_cfg_regs (
        .clk_ref, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .pll_locked, .power_mode, .recommended_mode,
        .domain_enable, .domain_stable, .total_power_mw, .prediction_mw,
        .pll_enable, .ml_enable, .global_mode
    );

    power_predictor u_power_predictor (
        .clk_ref, .rst_n, .ml_enable,
        .traffic_prediction, .thermal_state,
        .prediction_mw, .recommended_mode
    );

    pll_mode_ctrl u_pll_mode_ctrl (
        .clk_ref, .rst_n, .pll_enable, .ml_enable,
        .global_mode, .recommended_mode,
        .pll_locked, .power_mode
    );

    domain_gate_ctrl #(.num_lanes(num_lanes)) u_domain_gate_ctrl (
        .clk_ref, .rst_n, .pll_locked, .power_mode, .ml_enable,
        .lane_active, .activity_prediction,
        .domain_enable, .domain_stable, .lane_clock_enabled
    );

    vdd_ctrl u_vdd_ctrl (
        .clk_ref, .rst_n, .power_mode,
        .vdd_0p6_level, .vdd_0p8_level, .vdd_1p0_level, .vdd_aux_level,
        .current_voltage_mv
    );

    power_estimator u_power_estimator (
        .clk_ref, .rst_n, .domain_enable,
        .total_power_mw, .power_saved_mw
    );

endmodule

// ==== test/clk_pwr_checker.sv ====
`timescale 1ns/1ps

module clk_pwr_checker #(
    parameter int num_lanes = 16
) (
    input logic                                clk_ref,
    input logic                                rst_n,
    input logic                                psel,
    input logic                                penable,
    input logic                                pready,
    input logic                                pslverr,
    input logic                                pll_locked,
    input logic [clk_pwr_pkg::NUM_DOMAINS-1:0] domain_enable,
    input logic [num_lanes-1:0]                lane_clock_enabled
);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Enables follow the lock flag one register stage later
    a_no_domain_unlocked: assert property (@(posedge clk_ref) disable iff (!rst_n)
        (|domain_enable) |-> $past(pll_locked))
        else begin
            fail_count++;
            $error("domain enabled while the PLL was not locked");
        end

    a_lane_needs_dom0: assert property (@(posedge clk_ref) disable iff (!rst_n)
        (|lane_clock_enabled) |-> $past(domain_enable[0]))
        else begin
            fail_count++;
            $error("lane clock enabled without domain 0 one cycle earlier");
        end

    a_pready_high: assert property (@(posedge clk_ref) disable iff (!rst_n) pready)
        else begin
            fail_count++;
            $error("pready went low");
        end

    // Error flag belongs to the access phase only
    a_pslverr_access: assert property (@(posedge clk_ref) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else begin
            fail_count++;
            $error("pslverr raised outside an access phase");
        end

endmodule

bind clk_pwr_top clk_pwr_checker #(.num_lanes(num_lanes)) u_clk_pwr_checker (.*);

// ==== test/tb_clk_pwr_top.sv ====
`timescale 1ns/1ps

module tb_clk_pwr_top;

    localparam int NUM_LANES  = 16;
    localparam int CLK_PERIOD = 20;
    localparam int RUN_CYCLES = 20 + 100 + 60 + 100 + 50 + 80;  // Per-test budgets
    localparam int MARGIN     = 100;

    logic        clk_ref = 1'b0;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [31:0] pwdata, prdata;
    logic [NUM_LANES-1:0] lane_active, lane_clock_enabled;
    logic [7:0]  activity_prediction [clk_pwr_pkg::NUM_DOMAINS-1:0];
    logic [15:0] traffic_prediction, current_voltage_mv;
    logic [7:0]  thermal_state;
    logic        pll_locked;
    clk_pwr_pkg::power_mode_e power_mode, recommended_mode;
    logic [11:0] domain_enable, domain_stable;
    logic [2:0]  vdd_0p6_level, vdd_0p8_level, vdd_1p0_level, vdd_aux_level;
    logic [31:0] total_power_mw, power_saved_mw;
    integer      seed = 32'hde0b_aae9;

    clk_pwr_top #(.num_lanes(NUM_LANES)) u_clk_pwr_top (.*);

    always #(CLK_PERIOD / 2) clk_ref = ~clk_ref;

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "check on %s", name);
        end
    endtask

    // Both APB tasks start and end on a falling edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk_ref);
        penable = 1'b1;
        @(negedge clk_ref);  // Access edge E has passed
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk_ref);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        data = prdata;
        err = pslverr;
        @(negedge clk_ref);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_ctrl_and_settle(input logic [2:0] mode, input logic ml);
        apb_write(clk_pwr_pkg::ADDR_CTRL, {27'd0, mode, ml, 1'b1});
        repeat (3) @(negedge clk_ref);
    endtask

    // Ceiling table with the PLL locked
    function automatic logic [11:0] enables_for_mode(input int mode, input logic any_lane);
        logic [11:0] en;
        en = '0;
        if (mode <= 2 && any_lane) en[3:0] = 4'hf;
        if (mode <= 3) en[8:4] = 5'h1f;
        if (mode != 7) en[9] = 1'b1;
        if (mode <= 4) en[10] = 1'b1;
        if (mode <= 1) en[11] = 1'b1;
        return en;
    endfunction

    function automatic logic [31:0] power_for_enables(input logic [11:0] en);
        int unsigned mw [12] = '{800, 800, 800, 800, 200, 200, 200, 100, 100, 50, 25, 10};
        logic [31:0] sum;
        sum = 0;
        for (int d = 0; d < 12; d++)
            sum += en[d] ? mw[d] : 5;
        return sum;
    endfunction

    function automatic logic [2:0] rail_level(input int rail, input int mode);
        if (rail == 3) return (mode == 7) ? 3'd0 : 3'd5;  // Aux rail
        if (mode <= 3) return 3'(7 - mode);
        if (rail == 2 && mode == 4) return 3'd3;
        return 3'd0;
    endfunction

    function automatic int band_mode(input logic [31:0] sum);
        if (sum > 5000) return 3;
        if (sum > 3000) return 2;
        if (sum > 1000) return 1;
        return 0;
    endfunction

    task automatic reset_and_apb();
        logic [31:0] rd;
        logic err;
        check_eq("{pll_locked, power_mode, recommended_mode}", 7'b0_010_010,
                 {pll_locked, power_mode, recommended_mode});
        check_eq("{domain_stable, domain_enable}", 0, {domain_stable, domain_enable});
        check_eq("lane_clock_enabled", 0, lane_clock_enabled);
        check_eq("vdd levels", 0, {vdd_0p6_level, vdd_0p8_level, vdd_1p0_level, vdd_aux_level});
        check_eq("current_voltage_mv", 600, current_voltage_mv);
        check_eq("{total_power_mw, power_saved_mw}", 0, total_power_mw | power_saved_mw);
        rst_n = 1'b1;
        @(negedge clk_ref);
        apb_read(clk_pwr_pkg::ADDR_CTRL, rd, err);
        check_eq("ctrl after reset", 0, rd);
        apb_write(clk_pwr_pkg::ADDR_CTRL, 32'h0000_000d);
        apb_read(clk_pwr_pkg::ADDR_CTRL, rd, err);
        check_eq("ctrl readback", 32'h0000_000d, rd);
        apb_read(8'h20, rd, err);
        check_eq("pslverr unmapped", 1, err);
        check_eq("prdata unmapped", 0, rd);
    endtask

    task automatic mode_ceilings();
        logic [31:0] rd;
        logic err;
        lane_active = '1;
        for (int m = 0; m < 8; m++) begin
            apb_write(clk_pwr_pkg::ADDR_CTRL, {27'd0, 3'(m), 1'b0, 1'b1});
            repeat (2) @(negedge clk_ref);
            check_eq("domain_enable", enables_for_mode(m, 1'b1), domain_enable);
            @(negedge clk_ref);
            check_eq("vdd levels", {rail_level(0, m), rail_level(1, m), rail_level(2, m),
                     rail_level(3, m)}, {vdd_0p6_level, vdd_0p8_level, vdd_1p0_level,
                     vdd_aux_level});
            check_eq("current_voltage_mv", 600 + 50 * rail_level(0, m), current_voltage_mv);
            apb_read(clk_pwr_pkg::ADDR_DOMAINS, rd, err);
            check_eq("DOMAINS enables", enables_for_mode(m, 1'b1), rd[11:0]);
        end
    endtask

    task automatic lanes_and_symbols();
        logic [NUM_LANES-1:0] lanes;
        logic [11:0] en;
        for (int m = 2; m <= 3; m++) begin
            write_ctrl_and_settle(3'(m), 1'b0);
            for (int i = 0; i < 4; i++) begin
                lanes = NUM_LANES'($random(seed));
                lane_active = lanes;
                repeat (2) @(negedge clk_ref);
                en = enables_for_mode(m, |lanes);
                check_eq("domain_enable", en, domain_enable);
                check_eq("lane_clock_enabled", en[0] ? lanes : 0, lane_clock_enabled);
            end
        end
        lane_active = '1;
        write_ctrl_and_settle(clk_pwr_pkg::PWR_MEDIUM, 1'b0);
        lane_active = '0;  // Symbol domains lose their last lane
        repeat (2) @(negedge clk_ref);
        check_eq("domain_enable[3:0] idle", 0, domain_enable[3:0]);
        check_eq("lane_clock_enabled idle", 0, lane_clock_enabled);
    endtask

    task automatic power_estimate();
        logic [31:0] rd;
        logic [31:0] mw;
        logic err;
        lane_active = '1;
        for (int m = 0; m < 8; m++) begin
            write_ctrl_and_settle(3'(m), 1'b0);
            mw = power_for_enables(enables_for_mode(m, 1'b1));
            check_eq("total_power_mw", mw, total_power_mw);
            check_eq("power_saved_mw", 10000 - mw, power_saved_mw);
            apb_read(clk_pwr_pkg::ADDR_POWER, rd, err);
            check_eq("POWER register", mw, rd);
        end
    endtask

    task automatic prediction_path();
        logic [15:0] traffic [4] = '{16'd1500, 16'd900, 16'd400, 16'd100};
        logic [7:0] thermal [4] = '{8'd10, 8'd20, 8'd50, 8'd30};
        logic [31:0] sum;
        logic [2:0] band;
        logic [31:0] rd;
        logic err;
        write_ctrl_and_settle(clk_pwr_pkg::PWR_MAXIMUM, 1'b1);
        for (int i = 0; i < 4; i++) begin
            traffic_prediction = traffic[i];
            thermal_state = thermal[i];
            sum = 4 * traffic[i] + 2 * thermal[i];
            band = 3'(band_mode(sum));
            @(negedge clk_ref);  // T+1
            check_eq("prediction_mw", sum, u_clk_pwr_top.prediction_mw);
            @(negedge clk_ref);
            check_eq("recommended_mode", band, recommended_mode);
            @(negedge clk_ref);
            check_eq("power_mode", band, power_mode);
            apb_read(clk_pwr_pkg::ADDR_PREDICT, rd, err);
            check_eq("PREDICT register", sum, rd);
            apb_read(clk_pwr_pkg::ADDR_STATUS, rd, err);
            check_eq("STATUS register", {24'd0, 1'b0, band, 1'b1, band}, rd);
        end
    endtask

    task automatic activity_gating();
        logic [11:0] en;
        logic [31:0] rd;
        logic err;
        lane_active = '1;
        traffic_prediction = 16'd900;
        thermal_state = 8'd20;  // Medium band
        repeat (5) @(negedge clk_ref);
        en = enables_for_mode(2, 1'b1);
        check_eq("domain_enable medium", en, domain_enable);
        activity_prediction[4] = 8'($random(seed)) & 8'h3f;  // Below the off threshold
        @(negedge clk_ref);
        en[4] = 1'b0;
        check_eq("domain_enable gated", en, domain_enable);
        activity_prediction[0] = 8'hc1 + 8'($random(seed)) % 8'h3f;  // Above the hold threshold
        traffic_prediction = 16'd1500;  // Low band drops symbol domains
        thermal_state = 8'd10;
        repeat (5) @(negedge clk_ref);
        check_eq("power_mode", clk_pwr_pkg::PWR_LOW, power_mode);
        check_eq("domain_enable held", (enables_for_mode(3, 1'b1) & ~12'h010) | 12'h001,
                 domain_enable);
        activity_prediction[4] = 8'h80;
        repeat (17) @(negedge clk_ref);
        check_eq("domain_stable[4] early", 0, domain_stable[4]);
        @(negedge clk_ref);
        check_eq("domain_stable[4]", 1, domain_stable[4]);
        apb_read(clk_pwr_pkg::ADDR_DOMAINS, rd, err);
        check_eq("DOMAINS stable[4]", 1, rd[20]);
        activity_prediction[4] = 8'($random(seed)) & 8'h3f;
        @(negedge clk_ref);
        check_eq("{domain_enable[4], domain_stable[4]}", 2'b01,
                 {domain_enable[4], domain_stable[4]});
        @(negedge clk_ref);
        check_eq("domain_stable[4] cleared", 0, domain_stable[4]);
    endtask

    initial begin
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        lane_active = '0;
        traffic_prediction = '0;
        thermal_state = '0;
        for (int d = 0; d < clk_pwr_pkg::NUM_DOMAINS; d++)
            activity_prediction[d] = 8'h80;  // Neutral activity
        repeat (2) @(negedge clk_ref);
        reset_and_apb();
        mode_ceilings();
        lanes_and_symbols();
        power_estimate();
        prediction_path();
        activity_gating();
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (u_clk_pwr_top.u_clk_pwr_checker.fail_count != 0);
        $display("Assertion failed in the bound checker");
        $display("Some tests failed");
        $fatal(1, "checker assertion failed");
    end

    initial begin
        #((RUN_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", RUN_CYCLES + MARGIN);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sim.f ====
design/clk_pwr_pkg.sv
design/apb_cfg_regs.sv
design/power_predictor.sv
design/pll_mode_ctrl.sv
design/domain_gate_ctrl.sv
design/vdd_ctrl.sv
design/power_estimator.sv
design/clk_pwr_top.sv
test/clk_pwr_checker.sv
test/tb_clk_pwr_top.sv
